// ==== Makefile ====
VERILATOR  := verilator
VFLAGS     := --timing --assert
TOP        := led_matrix_tb
FILELIST   := led_matrix.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== led_matrix.f ====
logic/led_matrix_pkg.sv
logic/axil_frame_port.sv
logic/frame_buffer.sv
logic/scan_sequencer.sv
logic/led_matrix.sv
verif/led_matrix_chk.sv
verif/led_matrix_tb.sv

// ==== logic/axil_frame_port.sv ====
`timescale 1ns/1ps

module axil_frame_port #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3,
  localparam int ADDR_W = COL_BITS + ROW_BITS + 3,
  localparam int WORD_W = COL_BITS + ROW_BITS + 1,
  localparam int LANES = led_matrix_pkg::PIXEL_W / led_matrix_pkg::LEVEL_W
) (
  input  logic                                    led_clk,
  input  logic                                    rsi_reset_n,

  input  logic [ADDR_W-1:0]                       awaddr,
  input  logic                                    awvalid,
  output logic                                    awready,

  input  logic [led_matrix_pkg::AXI_DATA_W-1:0]   wdata,
  input  logic [led_matrix_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                    wvalid,
  output logic                                    wready,

  output logic [1:0]                              bresp,
  output logic                                    bvalid,
  input  logic                                    bready,

  input  logic [ADDR_W-1:0]                       araddr,
  input  logic                                    arvalid,
  output logic                                    arready,

  output logic [led_matrix_pkg::AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                              rresp,
  output logic                                    rvalid,
  input  logic                                    rready,

  output logic [WORD_W-1:0]                       host_addr,
  output logic [led_matrix_pkg::PIXEL_W-1:0]      host_wdata,
  output logic [LANES-1:0]                        host_be,
  output logic                                    host_we,
  input  logic [led_matrix_pkg::PIXEL_W-1:0]      host_rdata
);

  import led_matrix_pkg::*;

  logic              wr_accept;
  logic              rd_accept;
  logic              rd_issue;
  logic              rd_wait;
  logic [WORD_W-1:0] rd_addr;

  // ****************************************
  // Write channels
  // ****************************************

  // Address and data are taken together, and only while no response waits.
  // A write also holds off for the one cycle in which the shared port reads
  assign wr_accept = awvalid && wvalid && !bvalid && !rd_issue;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign host_we    = wr_accept;
  assign host_wdata = wdata[PIXEL_W-1:0];
  // The fourth byte lane has no storage behind it
  assign host_be    = wstrb[LANES-1:0];

  // Every address in the window is a pixel, so no error response exists
  assign bresp = OKAY;
  assign rresp = OKAY;

  always_ff @(posedge led_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // ****************************************
  // Read channels
  // ****************************************

  assign arready   = !(rd_issue || rd_wait || rvalid);
  assign rd_accept = arvalid && arready;

  // Byte offset bits are dropped to form the word address
  assign host_addr = rd_issue ? rd_addr : awaddr[ADDR_W-1:2];

  // rd_issue marks the cycle the memory is addressed, rd_wait the cycle its data returns
  always_ff @(posedge led_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      rd_issue <= 1'b0;
      rd_wait  <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      rd_issue <= rd_accept;
      rd_wait  <= rd_issue;
      if (rd_wait) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge led_clk) begin
    if (rd_accept) begin
      rd_addr <= araddr[ADDR_W-1:2];
    end
    if (rd_wait) begin
      rdata <= {{(AXI_DATA_W - PIXEL_W){1'b0}}, host_rdata};
    end
  end

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3,
  localparam int WORD_W = 1 + ROW_BITS + COL_BITS,
  localparam int LANES = led_matrix_pkg::PIXEL_W / led_matrix_pkg::LEVEL_W
) (
  input  logic                               led_clk,

  input  logic [WORD_W-1:0]                  host_addr,
  input  logic [led_matrix_pkg::PIXEL_W-1:0] host_wdata,
  input  logic [LANES-1:0]                   host_be,
  input  logic                               host_we,
  output logic [led_matrix_pkg::PIXEL_W-1:0] host_rdata,

  input  logic [WORD_W-1:0]                  scan_addr,
  output logic [led_matrix_pkg::PIXEL_W-1:0] scan_pixel
);

  import led_matrix_pkg::*;

  localparam int DEPTH = 2 ** WORD_W;

  // Top half pixels in the lower half of the array, bottom half above
  logic [PIXEL_W-1:0] mem [DEPTH];

  // Host port, one byte lane per colour level
  always_ff @(posedge led_clk) begin
    if (host_we) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (host_be[lane]) begin
          mem[host_addr][lane*LEVEL_W +: LEVEL_W] <= host_wdata[lane*LEVEL_W +: LEVEL_W];
        end
      end
    end
    host_rdata <= mem[host_addr];
  end

  // Scan port is read only
  always_ff @(posedge led_clk) begin
    scan_pixel <= mem[scan_addr];
  end

endmodule

// ==== logic/led_matrix.sv ====
`timescale 1ns/1ps

module led_matrix #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3,
  localparam int ADDR_W = COL_BITS + ROW_BITS + 3
) (
  input  logic                                    led_clk,
  input  logic                                    rsi_reset_n,

  input  logic [ADDR_W-1:0]                       awaddr,
  input  logic                                    awvalid,
  output logic                                    awready,
  input  logic [led_matrix_pkg::AXI_DATA_W-1:0]   wdata,
  input  logic [led_matrix_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                    wvalid,
  output logic                                    wready,
  output logic [1:0]                              bresp,
  output logic                                    bvalid,
  input  logic                                    bready,
  input  logic [ADDR_W-1:0]                       araddr,
  input  logic                                    arvalid,
  output logic                                    arready,
  output logic [led_matrix_pkg::AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                              rresp,
  output logic                                    rvalid,
  input  logic                                    rready,

  output logic [2:0]                              rgb0,
  output logic [2:0]                              rgb1,
  output logic                                    rgb_clk,
  output logic                                    rgb_stb,
  output logic                                    oe_n,
  output logic [ROW_BITS-1:0]                     demux
);

  import led_matrix_pkg::*;

  localparam int WORD_W = 1 + ROW_BITS + COL_BITS;
  localparam int LANES = PIXEL_W / LEVEL_W;

  logic [WORD_W-1:0]  host_addr;
  logic [PIXEL_W-1:0] host_wdata;
  logic [LANES-1:0]   host_be;
  logic               host_we;
  logic [PIXEL_W-1:0] host_rdata;
  logic [WORD_W-1:0]  scan_addr;
  logic [PIXEL_W-1:0] scan_pixel;

  axil_frame_port #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) u_port (
    .led_clk     (led_clk),
    .rsi_reset_n (rsi_reset_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_be     (host_be),
    .host_we     (host_we),
    .host_rdata  (host_rdata)
  );

  frame_buffer #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) u_mem (
    .led_clk    (led_clk),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_be    (host_be),
    .host_we    (host_we),
    .host_rdata (host_rdata),
    .scan_addr  (scan_addr),
    .scan_pixel (scan_pixel)
  );

  scan_sequencer #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) u_scan (
    .led_clk     (led_clk),
    .rsi_reset_n (rsi_reset_n),
    .scan_addr   (scan_addr),
    .scan_pixel  (scan_pixel),
    .rgb0        (rgb0),
    .rgb1        (rgb1),
    .rgb_clk     (rgb_clk),
    .rgb_stb     (rgb_stb),
    .oe_n        (oe_n),
    .demux       (demux)
  );

endmodule

// ==== logic/led_matrix_pkg.sv ====
package led_matrix_pkg;

  // ****************************************
  // Pixel and bus widths
  // ****************************************

  // Bits per colour level, which is also the number of bit-planes
  localparam int LEVEL_W = 8;
  localparam int PLANE_W = $clog2(LEVEL_W);

  // Red in the top byte, green in the middle, blue in the low byte
  localparam int PIXEL_W = 3 * LEVEL_W;

  localparam int AXI_DATA_W = 32;

  typedef enum logic [2:0] {
    SCAN_FETCH_TOP,
    SCAN_FETCH_BOT,
    SCAN_CAPTURE,
    SCAN_SHIFT,
    SCAN_LATCH,
    SCAN_SHOW
  } scan_state_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Output enable length of a bit-plane, halving from the top plane down
  function automatic logic [LEVEL_W-1:0] plane_on_time(input logic [PLANE_W-1:0] plane);
    logic [LEVEL_W-1:0] len;
    if (plane == PLANE_W'(LEVEL_W - 1)) begin
      len = '1;
    end else begin
      len = LEVEL_W'(1) << (plane + 1);
    end
    return len;
  endfunction

endpackage

// ==== logic/scan_sequencer.sv ====
`timescale 1ns/1ps

module scan_sequencer #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3,
  localparam int WORD_W = 1 + ROW_BITS + COL_BITS
) (
  input  logic                               led_clk,
  input  logic                               rsi_reset_n,

  output logic [WORD_W-1:0]                  scan_addr,
  input  logic [led_matrix_pkg::PIXEL_W-1:0] scan_pixel,

  output logic [2:0]                         rgb0,
  output logic [2:0]                         rgb1,
  output logic                               rgb_clk,
  output logic                               rgb_stb,
  output logic                               oe_n,
  output logic [ROW_BITS-1:0]                demux
);

  import led_matrix_pkg::*;

  scan_state_e         state;
  logic                half;
  logic [COL_BITS-1:0] col;
  logic [ROW_BITS-1:0] row;
  logic [PLANE_W-1:0]  plane;
  logic [LEVEL_W-1:0]  on_cnt;
  logic [2:0]          plane_bits;

  // ****************************************
  // Memory addressing and bit-plane select
  // ****************************************

  // half picks the bottom half of the panel
  assign scan_addr = {half, row, col};

  // Current plane's bit of red, green and blue
  assign plane_bits = {scan_pixel[2*LEVEL_W + plane],
                       scan_pixel[LEVEL_W + plane],
                       scan_pixel[plane]};

  // ****************************************
  // Panel control decode
  // ****************************************

  assign rgb_clk = (state == SCAN_SHIFT);
  assign rgb_stb = (state == SCAN_LATCH);
  assign oe_n    = (state != SCAN_SHOW);
  assign demux   = row;

  // ****************************************
  // Scan FSM
  // ****************************************

  always_ff @(posedge led_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state  <= SCAN_FETCH_TOP;
      half   <= 1'b0;
      col    <= '0;
      row    <= '0;
      plane  <= PLANE_W'(LEVEL_W - 1);
      on_cnt <= '0;
      rgb0   <= '0;
      rgb1   <= '0;
    end else begin
      case (state)
        SCAN_FETCH_TOP: begin
          half  <= 1'b1;
          state <= SCAN_FETCH_BOT;
        end
        SCAN_FETCH_BOT: begin
          // Top pixel arrives while the bottom one is addressed
          rgb0  <= plane_bits;
          half  <= 1'b0;
          state <= SCAN_CAPTURE;
        end
        SCAN_CAPTURE: begin
          rgb1  <= plane_bits;
          col   <= col + 1'b1;
          state <= SCAN_SHIFT;
        end
        SCAN_SHIFT: begin
          // Column counter wrapped, so the whole row has been shifted in
          if (col == '0) begin
            state <= SCAN_LATCH;
          end else begin
            state <= SCAN_FETCH_TOP;
          end
        end
        SCAN_LATCH: begin
          on_cnt <= plane_on_time(plane);
          state  <= SCAN_SHOW;
        end
        SCAN_SHOW: begin
          if (on_cnt == '0) begin
            // plane wraps from 0 back to the top plane of the next row
            plane <= plane - 1'b1;
            if (plane == '0) begin
              row <= row + 1'b1;
            end
            state <= SCAN_FETCH_TOP;
          end else begin
            on_cnt <= on_cnt - 1'b1;
          end
        end
        default: begin
          state <= SCAN_FETCH_TOP;
        end
      endcase
    end
  end

endmodule

// ==== verif/led_matrix_chk.sv ====
`timescale 1ns/1ps

module led_matrix_chk #(
  parameter int ROW_BITS = 3
) (
  input logic                led_clk,
  input logic                rsi_reset_n,
  input logic                rgb_clk,
  input logic                rgb_stb,
  input logic                oe_n,
  input logic [ROW_BITS-1:0] demux
);

  // Shift and latch pulses must never overlap the lit period
  a_no_pulse_while_lit: assert property (
    @(posedge led_clk) disable iff (!rsi_reset_n)
    !((rgb_clk || rgb_stb) && !oe_n)
  ) else $error("Shift or latch pulse while outputs are enabled");

  a_stb_not_with_clk: assert property (
    @(posedge led_clk) disable iff (!rsi_reset_n)
    !(rgb_stb && rgb_clk)
  ) else $error("Latch pulse together with shift pulse");

  // Row select moves only while the panel is dark
  a_demux_while_dark: assert property (
    @(posedge led_clk) disable iff (!rsi_reset_n)
    !$stable(demux) |-> oe_n
  ) else $error("Row select changed while outputs are enabled");

endmodule

bind led_matrix led_matrix_chk #(.ROW_BITS(ROW_BITS)) u_chk (.*);

// ==== verif/led_matrix_tb.sv ====
`timescale 1ns/1ps

module led_matrix_tb;

  import led_matrix_pkg::*;

  localparam int COL_BITS = 5;
  localparam int ROW_BITS = 3;
  localparam int ADDR_W = COL_BITS + ROW_BITS + 3;
  localparam int WORD_W = COL_BITS + ROW_BITS + 1;
  localparam int NPIX = 2 ** WORD_W;
  localparam int NCOL = 2 ** COL_BITS;
  localparam int NROW = 2 ** ROW_BITS;
  localparam int CLK_PERIOD = 4;
  localparam int N_RAND_WR = 256;
  localparam int N_RAND_RD = 256;

  logic              led_clk;
  logic              rsi_reset_n;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic [2:0]        rgb0;
  logic [2:0]        rgb1;
  logic              rgb_clk;
  logic              rgb_stb;
  logic              oe_n;
  logic [ROW_BITS-1:0] demux;

  logic [15:0]       lfsr;
  logic [23:0]       model [NPIX];

  led_matrix #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) u_dut (.*);

  always #(CLK_PERIOD / 2) led_clk = ~led_clk;

  // ****************************************
  // Helpers
  // ****************************************

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // Red is the top byte, blue the low byte
  function automatic logic [2:0] colour_bits(input logic [23:0] px, input int p);
    return {px[16 + p], px[8 + p], px[p]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    check_value("rgb_clk", rgb_clk, 0);
    check_value("rgb_stb", rgb_stb, 0);
    check_value("oe_n", oe_n, 1);
    check_value("demux", demux, 0);
    check_value("bvalid", bvalid, 0);
    check_value("rvalid", rvalid, 0);
  endtask

  // ****************************************
  // AXI4-Lite driver
  // ****************************************

  // Returns on the falling edge after the accepting edge, valid still high
  task automatic wait_write_accept();
    logic acc;
    acc = 1'b0;
    while (!acc) begin
      #1;
      acc = awready;
      check_value("wready", wready, awready);
      @(negedge led_clk);
    end
  endtask

  task automatic axi_write(input logic [WORD_W-1:0] word, input logic [31:0] data,
                           input logic [3:0] strb);
    int hold;
    hold = rand_bits(2);
    awaddr  = {word, 2'b00};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    wait_write_accept();
    for (int lane = 0; lane < 3; lane++) begin
      if (strb[lane]) begin
        model[word][lane*8 +: 8] = data[lane*8 +: 8];
      end
    end
    if (hold > 0) begin
      // Same write stays offered and must wait behind the pending response
      repeat (hold) begin
        #1;
        check_value("awready", awready, 0);
        check_value("bvalid", bvalid, 1);
        check_value("bresp", bresp, OKAY);
        @(negedge led_clk);
      end
      bready = 1'b1;
      wait_write_accept();
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    check_value("bvalid", bvalid, 1);
    check_value("bresp", bresp, OKAY);
    @(negedge led_clk);
    bready = 1'b0;
    check_value("bvalid", bvalid, 0);
  endtask

  task automatic axi_read(input logic [WORD_W-1:0] word);
    logic [31:0] exp;
    logic        acc;
    int          hold;
    int          lat;
    exp  = {8'h00, model[word]};
    hold = rand_bits(2);
    araddr  = {word, 2'b00};
    arvalid = 1'b1;
    rready  = 1'b0;
    acc = 1'b0;
    while (!acc) begin
      #1;
      acc = arready;
      @(negedge led_clk);
    end
    arvalid = 1'b0;
    lat = 0;
    while (!rvalid) begin
      check_value("arready", arready, 0);
      @(negedge led_clk);
      lat++;
    end
    check_value("read latency", lat, 2);
    repeat (hold) begin
      check_value("rvalid", rvalid, 1);
      check_value("rdata", rdata, exp);
      check_value("arready", arready, 0);
      @(negedge led_clk);
    end
    rready = 1'b1;
    check_value("rdata", rdata, exp);
    check_value("rresp", rresp, OKAY);
    @(negedge led_clk);
    rready = 1'b0;
    check_value("rvalid", rvalid, 0);
  endtask

  // ****************************************
  // Panel output checker
  // ****************************************

  task automatic check_frame();
    logic [ROW_BITS-1:0] row;
    logic [23:0]         top;
    logic [23:0]         bot;
    int                  col;
    int                  on_len;
    row = demux;
    // Start at the first column of a fresh row
    while (demux == row) begin
      @(negedge led_clk);
    end
    for (int r = 0; r < NROW; r++) begin
      row = demux;
      for (int p = LEVEL_W - 1; p >= 0; p--) begin
        col = 0;
        while (!rgb_stb) begin
          if (rgb_clk) begin
            assert (col < NCOL) else begin
              $display("More shift pulses than columns before the latch at %0t", $time);
              $display("TEST FAILED");
              $fatal(1);
            end
            top = model[{1'b0, row, col[COL_BITS-1:0]}];
            bot = model[{1'b1, row, col[COL_BITS-1:0]}];
            check_value("rgb0", rgb0, colour_bits(top, p));
            check_value("rgb1", rgb1, colour_bits(bot, p));
            col++;
          end
          check_value("demux", demux, row);
          @(negedge led_clk);
        end
        check_value("shift pulses per latch", col, NCOL);
        @(negedge led_clk);
        on_len = 0;
        while (!oe_n) begin
          on_len++;
          check_value("demux", demux, row);
          @(negedge led_clk);
        end
        check_value("oe_n low cycles", on_len, int'(plane_on_time(PLANE_W'(p))) + 1);
      end
      check_value("demux", demux, ROW_BITS'(row + 1));
    end
  endtask

  // ****************************************
  // Main sequence and watchdog
  // ****************************************

  initial begin
    led_clk     = 1'b0;
    rsi_reset_n = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    lfsr        = 16'd41101;
    repeat (8) begin
      @(negedge led_clk);
      check_idle();
    end
    rsi_reset_n = 1'b1;
    @(negedge led_clk);
    check_idle();
    check_value("rgb0", rgb0, 0);
    check_value("rgb1", rgb1, 0);
    // Every pixel once with all lanes, then random lanes on random pixels
    for (int w = 0; w < NPIX; w++) begin
      axi_write(WORD_W'(w), rand_bits(32), 4'hf);
    end
    repeat (N_RAND_WR) axi_write(WORD_W'(rand_bits(WORD_W)), rand_bits(32), 4'(rand_bits(4)));
    repeat (N_RAND_RD) axi_read(WORD_W'(rand_bits(WORD_W)));
    check_frame();
    $display("TEST OK");
    $finish;
  end

  initial begin
    int row_cycles;
    int bus_cycles;
    int limit;
    row_cycles = LEVEL_W * (NCOL * 4 + 2) + 8;
    for (int p = 0; p < LEVEL_W; p++) begin
      row_cycles += int'(plane_on_time(PLANE_W'(p)));
    end
    bus_cycles = (NPIX + N_RAND_WR + N_RAND_RD) * 16;
    limit = 2 * NROW * row_cycles + bus_cycles + 16;
    #(limit * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule
